/* vgen_timing_pkg.sv */
// raster counts stay below 2048; VRAM is 64K 16-bit words with one-cycle read data
package vgen_timing_pkg;

    typedef enum logic [1:0] {
        STATE_PRE_SYNC  = 2'b00,    // front porch
        STATE_SYNC      = 2'b01,
        STATE_POST_SYNC = 2'b10,    // back porch
        STATE_VISIBLE   = 2'b11
    } raster_state_t;

    typedef logic [10:0] raster_count_t;    // h or v position
    typedef logic [15:0] vram_addr_t;       // word address
    typedef logic [15:0] vram_word_t;
    typedef logic [7:0]  pixel_index_t;     // palette entry

endpackage

/* vgen_regs_pkg.sv */
// register numbers are 5 bits wide; numbers not listed here read back as zero
package vgen_regs_pkg;

    typedef enum logic [4:0] {
        XR_VID_CTRL  = 5'h00,   // colour base, interrupt trigger
        XR_SCANLINE  = 5'h01,   // read only
        XR_VID_HSIZE = 5'h02,
        XR_VID_VSIZE = 5'h03,
        XR_GFX_CTRL  = 5'h10,
        XR_DISP_ADDR = 5'h11,
        XR_LINE_LEN  = 5'h12
    } vgen_reg_t;

    typedef enum logic {
        BPP_4 = 1'b0,
        BPP_8 = 1'b1
    } pixel_depth_t;

    // gfx_ctrl field positions
    localparam int GFX_BASE_MSB  = 15;
    localparam int GFX_BASE_LSB  = 8;
    localparam int GFX_BLANK_BIT = 7;
    localparam int GFX_DEPTH_BIT = 4;

    typedef struct packed {
        logic [7:0]   colour_base;  // border colour, upper nibble for 4 bpp
        logic         blank;        // plane off, border only
        pixel_depth_t depth;
        logic [15:0]  start_addr;   // first word of the frame
        logic [15:0]  line_len;     // words from one line start to the next
    } gfx_config_t;

endpackage

/* vgen_sync_gen.sv */
// needs more than 12 offscreen columns per line so the first pixel group is fetched in time
`timescale 1ns/10ps

module vgen_sync_gen
    import vgen_timing_pkg::*;
#(
    parameter int   H_VISIBLE  = 640,
    parameter int   H_FRONT    = 16,
    parameter int   H_SYNC     = 96,
    parameter int   H_BACK     = 48,
    parameter int   V_VISIBLE  = 480,
    parameter int   V_FRONT    = 10,
    parameter int   V_SYNC     = 2,
    parameter int   V_BACK     = 33,
    parameter logic H_SYNC_POL = 1'b0,
    parameter logic V_SYNC_POL = 1'b0
) (
    input  logic          clk,
    input  logic          reset_i,
    output logic          hsync_o,
    output logic          vsync_o,
    output logic          dv_de_o,
    output raster_state_t h_state_o,
    output raster_state_t v_state_o,
    output raster_count_t v_count_o,
    output logic          line_fetch_start_o,
    output logic          scanout_start_o,
    output logic          frame_start_o,
    output logic          frame_end_o
);

    localparam int H_OFFSCREEN  = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL      = H_OFFSCREEN + H_VISIBLE;
    localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_FETCH_LEAD = 12;   // columns before first visible one

    raster_state_t h_state;
    raster_state_t v_state;
    raster_count_t h_count;
    raster_count_t v_count;
    raster_count_t h_limit;     // last count of current state
    raster_count_t v_limit;
    logic          line_end;

    always_comb begin
        case (h_state)
            STATE_PRE_SYNC:  h_limit = raster_count_t'(H_FRONT - 1);
            STATE_SYNC:      h_limit = raster_count_t'(H_FRONT + H_SYNC - 1);
            STATE_POST_SYNC: h_limit = raster_count_t'(H_OFFSCREEN - 1);
            default:         h_limit = raster_count_t'(H_TOTAL - 1);
        endcase
        // visible lines come first vertically
        case (v_state)
            STATE_VISIBLE:   v_limit = raster_count_t'(V_VISIBLE - 1);
            STATE_PRE_SYNC:  v_limit = raster_count_t'(V_VISIBLE + V_FRONT - 1);
            STATE_SYNC:      v_limit = raster_count_t'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:         v_limit = raster_count_t'(V_TOTAL - 1);
        endcase
    end

    assign line_end = (h_state == STATE_VISIBLE) && (h_count == h_limit);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= STATE_PRE_SYNC;
            v_state <= STATE_VISIBLE;       // line 0 starts in its front porch
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~H_SYNC_POL;
            vsync_o <= ~V_SYNC_POL;
            dv_de_o <= 1'b0;
        end else begin
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (line_end) begin
                v_count <= frame_start_o ? '0 : v_count + 1'b1;
            end
            if (h_count == h_limit) begin
                h_state <= raster_state_t'(h_state + 2'd1);
            end
            if (line_end && (v_count == v_limit)) begin
                v_state <= raster_state_t'(v_state + 2'd1);
            end
            hsync_o <= (h_state == STATE_SYNC) ? H_SYNC_POL : ~H_SYNC_POL;
            vsync_o <= (v_state == STATE_SYNC) ? V_SYNC_POL : ~V_SYNC_POL;
            dv_de_o <= (h_state == STATE_VISIBLE) && (v_state == STATE_VISIBLE);
        end
    end

    assign line_fetch_start_o = (v_state == STATE_VISIBLE) &&
                                (h_count == raster_count_t'(H_OFFSCREEN - H_FETCH_LEAD));
    assign scanout_start_o    = (v_state == STATE_VISIBLE) &&
                                (h_count == raster_count_t'(H_OFFSCREEN - 1));  // shifter loads here
    assign frame_start_o      = line_end && (v_state == STATE_POST_SYNC) && (v_count == v_limit);
    assign frame_end_o        = line_end && (v_state == STATE_VISIBLE) && (v_count == v_limit);

    assign h_state_o = h_state;
    assign v_state_o = v_state;
    assign v_count_o = v_count;

endmodule

/* vgen_regs.sv */
// reads return the register selected one cycle earlier; a write to vid_ctrl also sets the colour base
`timescale 1ns/10ps

module vgen_regs
    import vgen_timing_pkg::*;
    import vgen_regs_pkg::*;
#(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          vgen_reg_wr_i,
    input  vgen_reg_t     vgen_reg_num_i,
    input  vram_word_t    vgen_reg_data_i,
    output vram_word_t    vgen_reg_data_o,
    input  logic [3:0]    intr_status_i,
    output logic [3:0]    intr_signal_o,
    input  raster_state_t h_state_i,
    input  raster_state_t v_state_i,
    input  raster_count_t v_count_i,
    input  logic          frame_end_i,
    output gfx_config_t   cfg_o
);

    gfx_config_t cfg;
    vram_word_t  gfx_ctrl_rd;   // gfx_ctrl readback image

    assign cfg_o = cfg;

    always_comb begin
        gfx_ctrl_rd = '0;
        gfx_ctrl_rd[GFX_BASE_MSB:GFX_BASE_LSB] = cfg.colour_base;
        gfx_ctrl_rd[GFX_BLANK_BIT] = cfg.blank;
        gfx_ctrl_rd[GFX_DEPTH_BIT] = cfg.depth;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg.colour_base <= 8'h00;
            cfg.blank       <= 1'b0;
            cfg.depth       <= BPP_4;
            cfg.start_addr  <= '0;
            cfg.line_len    <= 16'(H_VISIBLE / 4);  // one 4-bpp line
            intr_signal_o   <= '0;
        end else begin
            intr_signal_o <= '0;
            if (vgen_reg_wr_i) begin
                case (vgen_reg_num_i)
                    XR_VID_CTRL: begin
                        cfg.colour_base <= vgen_reg_data_i[GFX_BASE_MSB:GFX_BASE_LSB];
                        intr_signal_o   <= vgen_reg_data_i[3:0];   // software trigger
                    end
                    XR_GFX_CTRL: begin
                        cfg.colour_base <= vgen_reg_data_i[GFX_BASE_MSB:GFX_BASE_LSB];
                        cfg.blank       <= vgen_reg_data_i[GFX_BLANK_BIT];
                        cfg.depth       <= pixel_depth_t'(vgen_reg_data_i[GFX_DEPTH_BIT]);
                    end
                    XR_DISP_ADDR: cfg.start_addr <= vgen_reg_data_i;
                    XR_LINE_LEN:  cfg.line_len   <= vgen_reg_data_i;
                    default: begin
                    end
                endcase
            end
            if (frame_end_i) begin
                intr_signal_o[3] <= 1'b1;   // vertical blank
            end
        end
    end

    always_ff @(posedge clk) begin
        case (vgen_reg_num_i)
            XR_VID_CTRL:  vgen_reg_data_o <= {cfg.colour_base, 4'h0, intr_status_i};
            XR_SCANLINE:  vgen_reg_data_o <= {(v_state_i != STATE_VISIBLE),
                                              (h_state_i != STATE_VISIBLE), 3'b000, v_count_i};
            XR_VID_HSIZE: vgen_reg_data_o <= 16'(H_VISIBLE);
            XR_VID_VSIZE: vgen_reg_data_o <= 16'(V_VISIBLE);
            XR_GFX_CTRL:  vgen_reg_data_o <= gfx_ctrl_rd;
            XR_DISP_ADDR: vgen_reg_data_o <= cfg.start_addr;
            XR_LINE_LEN:  vgen_reg_data_o <= cfg.line_len;
            default:      vgen_reg_data_o <= '0;
        endcase
    end

endmodule

/* vgen_bitmap_fetch.sv */
// H_VISIBLE must be a multiple of 8; blank is sampled only when a line fetch starts
`timescale 1ns/10ps

module vgen_bitmap_fetch
    import vgen_timing_pkg::*;
    import vgen_regs_pkg::*;
#(
    parameter int H_VISIBLE = 640
) (
    input  logic        clk,
    input  logic        reset_i,
    input  gfx_config_t cfg_i,
    input  logic        line_fetch_start_i,
    input  logic        frame_start_i,
    input  logic        next_taken_i,
    output logic        vram_sel_o,
    output vram_addr_t  vram_addr_o,
    input  vram_word_t  vram_data_i,
    output logic [63:0] next_pixels_o,
    output logic        next_ready_o
);

    localparam int GROUPS = H_VISIBLE / 8;  // 8-pixel groups per line

    typedef enum logic [2:0] {
        FC_SEL0   = 3'd0,   // word 0 out
        FC_SEL1   = 3'd1,
        FC_CAP0   = 3'd2,   // word 0 in, word 2 out at 8 bpp
        FC_CAP1   = 3'd3,
        FC_CAP2   = 3'd4,
        FC_CAP3   = 3'd5,
        FC_EXPAND = 3'd6,
        FC_NEXT   = 3'd7
    } fetch_cycle_t;

    fetch_cycle_t  cycle;
    logic          active;
    raster_count_t groups_left;
    vram_addr_t    fetch_addr;
    vram_addr_t    line_start;
    logic [63:0]   words;       // word 0 in the top 16 bits
    logic [63:0]   expanded;
    logic [1:0]    word_idx;
    logic          issue;       // VRAM read this cycle
    logic          hold;

    assign word_idx = cycle[1:0] - 2'd2;
    assign hold     = (cycle == FC_EXPAND) && next_ready_o && !next_taken_i;

    always_comb begin
        case (cycle)
            FC_SEL0, FC_SEL1: issue = active;
            FC_CAP0, FC_CAP1: issue = active && (cfg_i.depth == BPP_8);
            default:          issue = 1'b0;
        endcase
    end

    // leftmost pixel from the high end of word 0
    always_comb begin
        expanded = words;
        if (cfg_i.depth == BPP_4) begin
            for (int i = 0; i < 8; i++) begin
                expanded[63 - 8*i -: 8] = {cfg_i.colour_base[7:4], words[63 - 4*i -: 4]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cycle        <= FC_SEL0;
            active       <= 1'b0;
            groups_left  <= '0;
            fetch_addr   <= '0;
            line_start   <= '0;
            vram_sel_o   <= 1'b0;
            next_ready_o <= 1'b0;
        end else begin
            vram_sel_o <= issue;
            if (issue) begin
                fetch_addr <= fetch_addr + 1'b1;
            end
            if (next_taken_i) begin
                next_ready_o <= 1'b0;
            end
            if (active && !hold) begin
                cycle <= fetch_cycle_t'(cycle + 3'd1);
                if (cycle == FC_EXPAND) begin
                    next_ready_o <= 1'b1;
                end
                if (cycle == FC_NEXT) begin
                    active      <= (groups_left != '0);   // stop after last group
                    groups_left <= groups_left - 1'b1;
                end
            end
            if (line_fetch_start_i) begin
                active       <= !cfg_i.blank;
                cycle        <= FC_SEL0;
                groups_left  <= raster_count_t'(GROUPS - 1);
                fetch_addr   <= line_start;
                line_start   <= line_start + cfg_i.line_len;
                next_ready_o <= 1'b0;
            end
            if (frame_start_i) begin
                line_start <= cfg_i.start_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        vram_addr_o <= fetch_addr;
        if ((cycle >= FC_CAP0) && (cycle <= FC_CAP3)) begin
            words[63 - 16*word_idx -: 16] <= vram_data_i;
        end
        if (active && !hold && (cycle == FC_EXPAND)) begin
            next_pixels_o <= expanded;
        end
    end

endmodule

/* vgen_pixel_shift.sv */
// scanout ends at the first group boundary where no next buffer is ready
`timescale 1ns/10ps

module vgen_pixel_shift
    import vgen_timing_pkg::*;
    import vgen_regs_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  gfx_config_t  cfg_i,
    input  logic         scanout_start_i,
    input  logic         line_fetch_start_i,
    input  logic [63:0]  next_pixels_i,
    input  logic         next_ready_i,
    output logic         next_taken_o,
    output pixel_index_t color_index_o
);

    logic        scanning;
    logic [2:0]  pix_cnt;   // column within group
    logic [63:0] shift;
    logic        group_end;
    logic        load;

    assign group_end = scanout_start_i || (scanning && (pix_cnt == 3'd7));
    assign load      = group_end && next_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanning     <= 1'b0;
            pix_cnt      <= '0;
            next_taken_o <= 1'b0;
        end else begin
            next_taken_o <= load;
            pix_cnt      <= scanout_start_i ? 3'd0 : pix_cnt + 3'd1;
            if (group_end) begin
                scanning <= next_ready_i;
            end
            if (line_fetch_start_i) begin
                scanning <= 1'b0;   // new line, drop leftovers
            end
        end
    end

    always_ff @(posedge clk) begin
        shift         <= load ? next_pixels_i : {shift[55:0], 8'h00};
        color_index_o <= (scanning && !cfg_i.blank) ? shift[63:56] : cfg_i.colour_base;
    end

endmodule

/* vgen_top.sv */
// default raster is a tiny 32x8 frame for simulation; real modes override all parameters
`timescale 1ns/10ps

module vgen_top
    import vgen_timing_pkg::*;
    import vgen_regs_pkg::*;
#(
    parameter int   H_VISIBLE  = 32,
    parameter int   H_FRONT    = 4,
    parameter int   H_SYNC     = 4,
    parameter int   H_BACK     = 8,
    parameter int   V_VISIBLE  = 8,
    parameter int   V_FRONT    = 1,
    parameter int   V_SYNC     = 2,
    parameter int   V_BACK     = 1,
    parameter logic H_SYNC_POL = 1'b0,
    parameter logic V_SYNC_POL = 1'b0
) (
    input  logic         clk,
    input  logic         reset_i,
    input  logic         vgen_reg_wr_i,
    input  vgen_reg_t    vgen_reg_num_i,
    input  vram_word_t   vgen_reg_data_i,
    output vram_word_t   vgen_reg_data_o,
    input  logic [3:0]   intr_status_i,
    output logic [3:0]   intr_signal_o,
    output logic         vram_sel_o,
    output vram_addr_t   vram_addr_o,
    input  vram_word_t   vram_data_i,
    output pixel_index_t color_index_o,
    output logic         hsync_o,
    output logic         vsync_o,
    output logic         dv_de_o
);

    gfx_config_t   cfg;
    raster_state_t h_state;
    raster_state_t v_state;
    raster_count_t v_count;
    logic          line_fetch_start;
    logic          scanout_start;
    logic          frame_start;
    logic          frame_end;
    logic [63:0]   next_pixels;
    logic          next_ready;
    logic          next_taken;

    vgen_sync_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) u_sync_gen (
        .clk, .reset_i, .hsync_o, .vsync_o, .dv_de_o,
        .h_state_o(h_state), .v_state_o(v_state), .v_count_o(v_count),
        .line_fetch_start_o(line_fetch_start), .scanout_start_o(scanout_start),
        .frame_start_o(frame_start), .frame_end_o(frame_end)
    );

    vgen_regs #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)
    ) u_regs (
        .clk, .reset_i, .vgen_reg_wr_i, .vgen_reg_num_i, .vgen_reg_data_i, .vgen_reg_data_o,
        .intr_status_i, .intr_signal_o,
        .h_state_i(h_state), .v_state_i(v_state), .v_count_i(v_count),
        .frame_end_i(frame_end), .cfg_o(cfg)
    );

    vgen_bitmap_fetch #(
        .H_VISIBLE(H_VISIBLE)
    ) u_bitmap_fetch (
        .clk, .reset_i, .cfg_i(cfg),
        .line_fetch_start_i(line_fetch_start), .frame_start_i(frame_start),
        .next_taken_i(next_taken), .vram_sel_o, .vram_addr_o, .vram_data_i,
        .next_pixels_o(next_pixels), .next_ready_o(next_ready)
    );

    vgen_pixel_shift u_pixel_shift (
        .clk, .reset_i, .cfg_i(cfg),
        .scanout_start_i(scanout_start), .line_fetch_start_i(line_fetch_start),
        .next_pixels_i(next_pixels), .next_ready_i(next_ready),
        .next_taken_o(next_taken), .color_index_o
    );

endmodule

/* vgen_assert.sv */
// bound into every vgen_sync_gen; takes raster sizes and polarities from the bound instance
`timescale 1ns/10ps

module vgen_assert #(
    parameter int   H_VISIBLE  = 32,
    parameter int   H_FRONT    = 4,
    parameter int   H_SYNC     = 4,
    parameter logic H_SYNC_POL = 1'b0,
    parameter logic V_SYNC_POL = 1'b0
) (
    input logic clk,
    input logic reset_i,
    input logic hsync_o,
    input logic vsync_o,
    input logic dv_de_o,
    input logic frame_end_o
);

    int   fail_count = 0;
    logic h_act;
    logic v_act;

    assign h_act = (hsync_o == H_SYNC_POL);
    assign v_act = (vsync_o == V_SYNC_POL);

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $rose(h_act) |-> h_act [*H_SYNC] ##1 !h_act)
        else begin
            fail_count++;
            $error("hsync active width differs from H_SYNC");
        end

    // front porch lies between the last enabled column and the sync pulse
    de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        $fell(dv_de_o) |-> (!h_act) [*H_FRONT] ##1 h_act)
        else begin
            fail_count++;
            $error("display enable end and hsync start not one front porch apart");
        end

    // frame end drives the vertical blank interrupt
    frame_end_pulse: assert property (@(posedge clk) disable iff (reset_i)
        frame_end_o |=> dv_de_o ##1 (!dv_de_o) [*H_VISIBLE])
        else begin
            fail_count++;
            $error("frame end pulse not on the last visible pixel of the frame");
        end

endmodule

bind vgen_sync_gen vgen_assert #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC),
    .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
) u_assert (.*);

/* vgen_tb.sv */
// small 32x8 raster; vram model answers one cycle after each select; needs a simulator with assertions
`timescale 1ns/10ps

module vgen_tb
    import vgen_timing_pkg::*;
    import vgen_regs_pkg::*;
;
    localparam int   H_VISIBLE    = 32;
    localparam int   H_FRONT      = 4;
    localparam int   H_SYNC       = 4;
    localparam int   H_BACK       = 8;
    localparam int   V_VISIBLE    = 8;
    localparam int   V_FRONT      = 1;
    localparam int   V_SYNC       = 2;
    localparam int   V_BACK       = 1;
    localparam logic H_SYNC_POL   = 1'b0;
    localparam logic V_SYNC_POL   = 1'b0;
    localparam int   H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int   FRAME_CYCLES = H_TOTAL * (V_VISIBLE + V_FRONT + V_SYNC + V_BACK);
    localparam int   CLK_PERIOD   = 8;
    localparam int   DRIVE_DELAY  = 1;
    localparam int   RESET_CYCLES = 10;
    localparam int   WATCHDOG_CYCLES = RESET_CYCLES + 20 * FRAME_CYCLES + 200;  // about 12 frames used

    logic         clk = 1'b0;
    logic         reset_i = 1'b1;
    logic         vgen_reg_wr_i = 1'b0;
    vgen_reg_t    vgen_reg_num_i = XR_VID_CTRL;
    vram_word_t   vgen_reg_data_i = '0;
    vram_word_t   vgen_reg_data_o;
    logic [3:0]   intr_status_i = 4'h0;
    logic [3:0]   intr_signal_o;
    logic         vram_sel_o;
    vram_addr_t   vram_addr_o;
    vram_word_t   vram_data_i = '0;
    pixel_index_t color_index_o;
    logic         hsync_o;
    logic         vsync_o;
    logic         dv_de_o;

    int word_errors = 0;
    int pixel_errors = 0;
    int flag_errors = 0;
    int count_errors = 0;
    vram_word_t vram_key;       // scrambles the vram fill

    logic [7:0] m_base;         // expected configuration
    logic       m_blank;
    logic       m_bpp8;
    vram_addr_t m_start;
    vram_word_t m_len;

    vgen_top #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) u_vgen_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic vram_word_t vram_word(vram_addr_t a);
        return vram_word_t'(a * 16'd40503) ^ vram_key;  // odd multiplier, whole address counts
    endfunction

    // synchronous RAM, data one cycle after the select
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= #DRIVE_DELAY vram_word(vram_addr_o);
        end
    end

    function automatic pixel_index_t expect_pixel(int line, int col);
        vram_addr_t addr;
        vram_word_t w;
        if (m_blank) begin
            return m_base;
        end
        if (m_bpp8) begin
            addr = vram_addr_t'(m_start + line * m_len + col / 2);
            w = vram_word(addr);
            return (col % 2 == 0) ? w[15:8] : w[7:0];
        end
        addr = vram_addr_t'(m_start + line * m_len + col / 4);
        w = vram_word(addr);
        return {m_base[7:4], w[15 - 4 * (col % 4) -: 4]};
    endfunction

    task automatic check_word(input vram_word_t got, input vram_word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input pixel_index_t got, input pixel_index_t exp, input string what);
        if (got !== exp) begin
            pixel_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            count_errors++;
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input vgen_reg_t num, input vram_word_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        vgen_reg_wr_i = 1'b1;
        vgen_reg_num_i = num;
        vgen_reg_data_i = data;
        @(posedge clk);
        #DRIVE_DELAY;
        vgen_reg_wr_i = 1'b0;
    endtask

    task automatic read_reg(input vgen_reg_t num, output vram_word_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        vgen_reg_num_i = num;
        @(posedge clk);
        @(negedge clk);
        data = vgen_reg_data_o;
    endtask

    task automatic set_config(input logic [7:0] base, input logic blank, input logic bpp8,
                              input vram_addr_t start, input vram_word_t len);
        write_reg(XR_GFX_CTRL, {base, blank, 2'b00, bpp8, 4'h0});
        write_reg(XR_DISP_ADDR, start);
        write_reg(XR_LINE_LEN, len);
        m_base = base;
        m_blank = blank;
        m_bpp8 = bpp8;
        m_start = start;
        m_len = len;
    endtask

    task automatic wait_vsync_start();
        @(negedge clk);
        while (vsync_o == V_SYNC_POL) @(negedge clk);
        while (vsync_o != V_SYNC_POL) @(negedge clk);
    endtask

    // returns in the back porch, before the frame start address is taken
    task automatic wait_frame_start();
        wait_vsync_start();
        while (vsync_o == V_SYNC_POL) @(negedge clk);
    endtask

    task automatic check_frame(input string mode);
        int line;
        int col;
        line = 0;
        col = 0;
        while (line < V_VISIBLE) begin
            @(negedge clk);
            if (m_blank) begin
                check_flag(vram_sel_o, 1'b0, $sformatf("%s vram select", mode));
            end
            if (dv_de_o) begin
                check_pixel(color_index_o, expect_pixel(line, col),
                            $sformatf("%s pixel line %0d col %0d", mode, line, col));
                col++;
                if (col == H_VISIBLE) begin
                    col = 0;
                    line++;
                end
            end
        end
    endtask

    task automatic run_register_readback();
        vram_word_t rd;
        read_reg(XR_VID_HSIZE, rd);
        check_word(rd, 16'(H_VISIBLE), "vid_hsize");
        read_reg(XR_VID_VSIZE, rd);
        check_word(rd, 16'(V_VISIBLE), "vid_vsize");
        write_reg(XR_GFX_CTRL, 16'hA590);
        read_reg(XR_GFX_CTRL, rd);
        check_word(rd, 16'hA590, "gfx_ctrl readback");
        write_reg(XR_DISP_ADDR, 16'h1234);
        read_reg(XR_DISP_ADDR, rd);
        check_word(rd, 16'h1234, "disp_addr readback");
        write_reg(XR_LINE_LEN, 16'h0020);
        read_reg(XR_LINE_LEN, rd);
        check_word(rd, 16'h0020, "line_len readback");
    endtask

    task automatic run_raster_timing();
        int width;
        int period;
        int de_cycles;
        int vsync_cycles;
        @(negedge clk);
        while (hsync_o == H_SYNC_POL) @(negedge clk);
        while (hsync_o != H_SYNC_POL) @(negedge clk);
        width = 0;
        while (hsync_o == H_SYNC_POL) begin
            width++;
            @(negedge clk);
        end
        period = width;
        while (hsync_o != H_SYNC_POL) begin
            period++;
            @(negedge clk);
        end
        check_count(width, H_SYNC, "hsync width");
        check_count(period, H_TOTAL, "hsync period");
        wait_vsync_start();
        de_cycles = 0;
        vsync_cycles = 0;
        while (vsync_o == V_SYNC_POL) begin
            vsync_cycles++;
            @(negedge clk);
            de_cycles += dv_de_o;
        end
        while (vsync_o != V_SYNC_POL) begin
            @(negedge clk);
            de_cycles += dv_de_o;
        end
        check_count(vsync_cycles, V_SYNC * H_TOTAL, "vsync width in cycles");
        check_count(de_cycles, H_VISIBLE * V_VISIBLE, "display enable cycles per frame");
    endtask

    task automatic run_interrupts();
        vram_word_t rd;
        int pulses;
        intr_status_i = 4'h6;
        wait_frame_start();     // well clear of the frame end pulse
        write_reg(XR_VID_CTRL, 16'h4B05);
        m_base = 8'h4B;
        @(negedge clk);
        check_word(vram_word_t'(intr_signal_o), 16'h0005, "intr pulse after vid_ctrl write");
        @(negedge clk);
        check_word(vram_word_t'(intr_signal_o), 16'h0000, "intr one cycle later");
        read_reg(XR_VID_CTRL, rd);
        check_word(rd, 16'h4B06, "vid_ctrl read");
        wait_frame_start();
        pulses = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            pulses += intr_signal_o[3];
        end
        check_count(pulses, 1, "vertical blank interrupts per frame");
        while (!intr_signal_o[3]) @(negedge clk);
        read_reg(XR_SCANLINE, rd);
        check_flag(rd[15], 1'b1, "scanline vertical not-visible flag");
        check_word(rd, {2'b11, 3'b000, 11'(V_VISIBLE)}, "scanline after frame end");
    endtask

    initial begin
        int assert_fails;
        void'($urandom(32'h9ee9_b5ea));
        vram_key = vram_word_t'($urandom);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        run_register_readback();
        run_raster_timing();
        set_config(8'h3C, 1'b0, 1'b1, 16'h0100, 16'd20);
        wait_frame_start();
        check_frame("8 bpp");
        set_config(8'h5A, 1'b0, 1'b0, 16'hFFF8, 16'd9);    // start wraps the address space
        wait_frame_start();
        check_frame("4 bpp");
        set_config(8'h77, 1'b1, 1'b0, 16'h0040, 16'd8);
        wait_frame_start();
        check_frame("blank");
        run_interrupts();
        assert_fails = u_vgen_top.u_sync_gen.u_assert.fail_count;
        $display("summary: %0d word, %0d pixel, %0d flag, %0d count errors, %0d assertion failures",
                 word_errors, pixel_errors, flag_errors, count_errors, assert_fails);
        if (word_errors + pixel_errors + flag_errors + count_errors + assert_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* vgen.f */
vgen_timing_pkg.sv
vgen_regs_pkg.sv
vgen_sync_gen.sv
vgen_regs.sv
vgen_bitmap_fetch.sv
vgen_pixel_shift.sv
vgen_top.sv
vgen_assert.sv
vgen_tb.sv
